//--- cpu_top.f
+incdir+include
design/cpu_pkg.sv
design/ir_controller.sv
design/instr_mem.sv
design/reg_file.sv
design/exec_unit.sv
design/data_mem.sv
design/cpu_top.sv
test/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run into sim.log, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module cpu_tb -f cpu_top.f -o cpu_tb_sim \
  && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1

//--- test/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb;

  localparam int halt_timeout = 2000;

  logic                   clock;
  logic                   reset;
  logic                   run;
  logic                   im_load;
  logic [`CPU_IM_AW-1:0]  im_load_addr;
  logic [`CPU_DATA_W-1:0] im_load_data;
  logic [`CPU_REG_AW-1:0] dbg_reg_addr;
  logic [`CPU_DM_AW-1:0]  dbg_dm_addr;
  logic                   halted;
  logic [`CPU_CNT_W-1:0]  ins_cnt;
  logic [`CPU_DATA_W-1:0] dbg_reg_data;
  logic [`CPU_DATA_W-1:0] dbg_dm_data;

  int                     errors;
  logic                   hung;
  logic [31:0]            rng_state;
  logic [`CPU_CNT_W-1:0]  run_cycles;
  logic [`CPU_DATA_W-1:0] prog [$];

  cpu_top u_dut (
    .clock, .reset, .run, .im_load, .im_load_addr, .im_load_data,
    .dbg_reg_addr, .dbg_dm_addr, .halted, .ins_cnt, .dbg_reg_data, .dbg_dm_data
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic cpu_pkg::insn_u alu_insn(cpu_pkg::basic_sub_e sub, logic [4:0] rt,
                                              logic [4:0] ra, logic [4:0] rb_imm5);
    cpu_pkg::insn_u w;
    w = '0;
    w.alu_f.opcode  = cpu_pkg::op_type_basic;
    w.alu_f.rt      = rt;
    w.alu_f.ra      = ra;
    w.alu_f.rb_imm5 = rb_imm5;
    w.alu_f.sub     = sub;
    return w;
  endfunction

  function automatic cpu_pkg::insn_u imm15_insn(cpu_pkg::opcode_e op, logic [4:0] rt,
                                                logic [4:0] ra, logic [14:0] imm15);
    cpu_pkg::insn_u w;
    w = '0;
    w.imm15_f.opcode = op;
    w.imm15_f.rt     = rt;
    w.imm15_f.ra     = ra;
    w.imm15_f.imm15  = imm15;
    return w;
  endfunction

  function automatic cpu_pkg::insn_u movi_insn(logic [4:0] rt, logic [19:0] imm20);
    cpu_pkg::insn_u w;
    w = '0;
    w.imm20_f.opcode = cpu_pkg::op_movi;
    w.imm20_f.rt     = rt;
    w.imm20_f.imm20  = imm20;
    return w;
  endfunction

  function automatic cpu_pkg::insn_u ls_insn(cpu_pkg::ls_sub_e sub, logic [4:0] rt,
                                             logic [4:0] ra, logic [4:0] rb, logic [1:0] sv);
    cpu_pkg::insn_u w;
    w = '0;
    w.ls_f.opcode = cpu_pkg::op_type_ls;
    w.ls_f.rt     = rt;
    w.ls_f.ra     = ra;
    w.ls_f.rb     = rb;
    w.ls_f.sv     = sv;
    w.ls_f.sub    = sub;
    return w;
  endfunction

  function automatic logic [`CPU_DATA_W-1:0] sext20(logic [19:0] v);
    return {{(`CPU_DATA_W-20){v[19]}}, v};
  endfunction

  task automatic push_insn(cpu_pkg::insn_u w);
    prog.push_back(w);
  endtask

  task automatic apply_reset();
    @(negedge clock);
    reset = 1'b1;
    run   = 1'b0;
    repeat (8) @(negedge clock);
    reset = 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(negedge clock);
      im_load      = 1'b1;
      im_load_addr = `CPU_IM_AW'(`CPU_IM_START + i);
      im_load_data = prog[i];
    end
    @(negedge clock);
    im_load = 1'b0;
    prog.delete();
  endtask

  // cycles counted from the negedge that raises run
  task automatic run_until_halt();
    int cycles;
    cycles = 0;
    @(negedge clock);
    run = 1'b1;
    while (!halted && cycles < halt_timeout) begin
      @(negedge clock);
      cycles++;
    end
    run        = 1'b0;
    run_cycles = `CPU_CNT_W'(cycles);
    if (!halted) begin
      $display("Timeout: the core never halted within %0d cycles", halt_timeout);
      hung = 1'b1;
    end
  endtask

  task automatic check_word(string what, logic [`CPU_DATA_W-1:0] got,
                            logic [`CPU_DATA_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(string what, logic [`CPU_CNT_W-1:0] got,
                             logic [`CPU_CNT_W-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(string what, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_reg(logic [`CPU_REG_AW-1:0] addr, logic [`CPU_DATA_W-1:0] exp);
    @(negedge clock);
    dbg_reg_addr = addr;
    #1;
    check_word($sformatf("r%0d", addr), dbg_reg_data, exp);
  endtask

  task automatic check_mem(logic [`CPU_DM_AW-1:0] addr, logic [`CPU_DATA_W-1:0] exp);
    @(negedge clock);
    dbg_dm_addr = addr;
    #1;
    check_word($sformatf("dm[%0d]", addr), dbg_dm_data, exp);
  endtask

  task automatic test_immediates();
    logic [19:0]            neg20;
    logic [19:0]            pos20;
    logic [14:0]            neg15;
    logic [14:0]            ze15;
    logic [`CPU_DATA_W-1:0] r1;
    logic [`CPU_DATA_W-1:0] r2;
    neg20 = 20'h80005;
    pos20 = 20'h71234;
    neg15 = 15'h7ff0;
    ze15  = 15'h4001;
    r1    = sext20(neg20);
    r2    = sext20(pos20);
    apply_reset();
    push_insn(movi_insn(5'd1, neg20));
    push_insn(movi_insn(5'd2, pos20));
    push_insn(imm15_insn(cpu_pkg::op_addi, 5'd3, 5'd2, neg15));
    push_insn(imm15_insn(cpu_pkg::op_ori, 5'd4, 5'd1, ze15));
    push_insn(imm15_insn(cpu_pkg::op_xori, 5'd5, 5'd1, 15'h7fff));
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      check_reg(5'd1, r1);
      check_reg(5'd2, r2);
      check_reg(5'd3, r2 + {{(`CPU_DATA_W-15){neg15[14]}}, neg15});
      check_reg(5'd4, r1 | {{(`CPU_DATA_W-15){1'b0}}, ze15});
      check_reg(5'd5, r1 ^ {{(`CPU_DATA_W-15){1'b0}}, 15'h7fff});
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(5));
    end
  endtask

  task automatic test_alu_ops();
    logic [31:0]            ra_word;
    logic [31:0]            rb_word;
    logic [31:0]            sh_word;
    logic [4:0]             sh_l;
    logic [4:0]             sh_r;
    logic [4:0]             sh_rot;
    logic [`CPU_DATA_W-1:0] a;
    logic [`CPU_DATA_W-1:0] b;
    ra_word = next_rand();
    rb_word = next_rand();
    sh_word = next_rand();
    sh_l    = sh_word[4:0];
    // srli by zero would decode as nop
    sh_r    = (sh_word[9:5] == 5'd0) ? 5'd1 : sh_word[9:5];
    sh_rot  = (sh_word[14:10] == 5'd0) ? 5'd1 : sh_word[14:10];
    a = sext20(ra_word[19:0]) | {{(`CPU_DATA_W-15){1'b0}}, ra_word[30:16]};
    b = sext20(rb_word[19:0]) | {{(`CPU_DATA_W-15){1'b0}}, rb_word[30:16]};
    apply_reset();
    push_insn(movi_insn(5'd1, ra_word[19:0]));
    push_insn(imm15_insn(cpu_pkg::op_ori, 5'd1, 5'd1, ra_word[30:16]));
    push_insn(movi_insn(5'd2, rb_word[19:0]));
    push_insn(imm15_insn(cpu_pkg::op_ori, 5'd2, 5'd2, rb_word[30:16]));
    push_insn(alu_insn(cpu_pkg::sub_add, 5'd3, 5'd1, 5'd2));
    push_insn(alu_insn(cpu_pkg::sub_sub, 5'd4, 5'd1, 5'd2));
    push_insn(alu_insn(cpu_pkg::sub_and, 5'd5, 5'd1, 5'd2));
    push_insn(alu_insn(cpu_pkg::sub_or, 5'd6, 5'd1, 5'd2));
    push_insn(alu_insn(cpu_pkg::sub_xor, 5'd7, 5'd1, 5'd2));
    push_insn(alu_insn(cpu_pkg::sub_slli, 5'd8, 5'd1, sh_l));
    push_insn(alu_insn(cpu_pkg::sub_srli, 5'd9, 5'd2, sh_r));
    push_insn(alu_insn(cpu_pkg::sub_rotri, 5'd10, 5'd1, sh_rot));
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      check_reg(5'd1, a);
      check_reg(5'd2, b);
      check_reg(5'd3, a + b);
      check_reg(5'd4, a - b);
      check_reg(5'd5, a & b);
      check_reg(5'd6, a | b);
      check_reg(5'd7, a ^ b);
      check_reg(5'd8, a << sh_l);
      check_reg(5'd9, b >> sh_r);
      check_reg(5'd10, (a >> sh_rot) | (a << (6'd32 - {1'b0, sh_rot})));
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(12));
    end
  endtask

  task automatic test_memory();
    logic [31:0]            d0_word;
    logic [31:0]            d1_word;
    logic [14:0]            off;
    logic [`CPU_DATA_W-1:0] base;
    logic [`CPU_DATA_W-1:0] ea0;
    logic [`CPU_DATA_W-1:0] ea1;
    d0_word = next_rand();
    d1_word = next_rand();
    off     = 15'h40e5;
    base    = `CPU_DATA_W'(16);
    // offset form zero-extends imm15 and indexed form scales rb by sv
    ea0 = base + {{(`CPU_DATA_W-15){1'b0}}, off};
    ea1 = base + (`CPU_DATA_W'(3) << 2);
    apply_reset();
    push_insn(movi_insn(5'd1, 20'd16));
    push_insn(movi_insn(5'd2, d0_word[19:0]));
    push_insn(imm15_insn(cpu_pkg::op_swi, 5'd2, 5'd1, off));
    push_insn(imm15_insn(cpu_pkg::op_lwi, 5'd3, 5'd1, off));
    push_insn(movi_insn(5'd4, 20'd3));
    push_insn(movi_insn(5'd5, d1_word[19:0]));
    push_insn(ls_insn(cpu_pkg::ls_sw, 5'd5, 5'd1, 5'd4, 2'd2));
    push_insn(ls_insn(cpu_pkg::ls_lw, 5'd6, 5'd1, 5'd4, 2'd2));
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      check_reg(5'd3, sext20(d0_word[19:0]));
      check_reg(5'd6, sext20(d1_word[19:0]));
      check_mem(ea0[`CPU_DM_AW-1:0], sext20(d0_word[19:0]));
      check_mem(ea1[`CPU_DM_AW-1:0], sext20(d1_word[19:0]));
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(8));
    end
  endtask

  task automatic test_nop();
    logic [`CPU_DATA_W-1:0] exp_regs [2**`CPU_REG_AW];
    foreach (exp_regs[i]) begin
      exp_regs[i] = '0;
    end
    exp_regs[1] = sext20(20'h12345);
    exp_regs[2] = sext20(20'hfedcb);
    exp_regs[3] = sext20(20'h00777);
    apply_reset();
    push_insn(movi_insn(5'd1, 20'h12345));
    push_insn(movi_insn(5'd2, 20'hfedcb));
    // would copy r2 into r1 if it wrote back
    push_insn(alu_insn(cpu_pkg::sub_srli, 5'd1, 5'd2, 5'd0));
    push_insn(movi_insn(5'd3, 20'h00777));
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        check_reg(`CPU_REG_AW'(i), exp_regs[i]);
      end
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(4));
    end
  endtask

  task automatic test_halt_count();
    int n;
    n = 7;
    apply_reset();
    for (int i = 0; i < n; i++) begin
      push_insn(imm15_insn(cpu_pkg::op_addi, 5'd1, 5'd1, 15'd1));
    end
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      check_flag("halted", halted, 1'b1);
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(n));
      // eight cycles per instruction plus stop and fetch of the zero word
      check_count("cycles to halt", run_cycles, `CPU_CNT_W'(8 * n + 2));
      check_reg(5'd1, `CPU_DATA_W'(n));
      // a nonzero word at the halt pc must not run while halted
      for (int i = 0; i <= n; i++) begin
        push_insn(imm15_insn(cpu_pkg::op_addi, 5'd1, 5'd1, 15'd1));
      end
      load_program();
      run = 1'b1;
      repeat (16) @(negedge clock);
      run = 1'b0;
      check_flag("halted after idle", halted, 1'b1);
      check_count("ins_cnt after idle", ins_cnt, `CPU_CNT_W'(n));
      check_reg(5'd1, `CPU_DATA_W'(n));
    end
  endtask

  task automatic test_restart();
    apply_reset();
    #1;
    check_flag("halted after reset", halted, 1'b0);
    check_count("ins_cnt after reset", ins_cnt, `CPU_CNT_W'(0));
    push_insn(movi_insn(5'd7, 20'h2468a));
    push_insn(imm15_insn(cpu_pkg::op_xori, 5'd8, 5'd7, 15'h1234));
    push_insn('0);
    load_program();
    run_until_halt();
    if (!hung) begin
      check_count("ins_cnt", ins_cnt, `CPU_CNT_W'(2));
      check_reg(5'd1, '0);
      check_reg(5'd7, sext20(20'h2468a));
      check_reg(5'd8, sext20(20'h2468a) ^ {{(`CPU_DATA_W-15){1'b0}}, 15'h1234});
    end
  endtask

  initial begin
    clock        = 1'b0;
    reset        = 1'b1;
    run          = 1'b0;
    im_load      = 1'b0;
    im_load_addr = '0;
    im_load_data = '0;
    dbg_reg_addr = '0;
    dbg_dm_addr  = '0;
    errors       = 0;
    hung         = 1'b0;
    run_cycles   = '0;
    rng_state    = 32'hf6c32b15;

    test_immediates();
    if (!hung) test_alu_ops();
    if (!hung) test_memory();
    if (!hung) test_nop();
    if (!hung) test_halt_count();
    if (!hung) test_restart();

    $display("checks done: %0d errors, %0d timeouts", errors, hung ? 1 : 0);
    if (errors == 0 && !hung) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- design/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module cpu_top (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic                   run,
  input  wire logic                   im_load,
  input  wire logic [`CPU_IM_AW-1:0]  im_load_addr,
  input  wire logic [`CPU_DATA_W-1:0] im_load_data,
  input  wire logic [`CPU_REG_AW-1:0] dbg_reg_addr,
  input  wire logic [`CPU_DM_AW-1:0]  dbg_dm_addr,
  output logic                        halted,
  output logic [`CPU_CNT_W-1:0]       ins_cnt,
  output logic [`CPU_DATA_W-1:0]      dbg_reg_data,
  output logic [`CPU_DATA_W-1:0]      dbg_dm_data
);

  cpu_pkg::insn_u         fetch_word;
  cpu_pkg::insn_u         insn;
  cpu_pkg::ctrl_s         ctrl;
  logic [`CPU_IM_AW-1:0]  im_address;
  logic                   im_read;
  logic [`CPU_DATA_W-1:0] ra_data;
  logic [`CPU_DATA_W-1:0] rb_data;
  logic [`CPU_DATA_W-1:0] rt_data;
  logic [`CPU_DATA_W-1:0] dm_data;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] writeback_data;

  ir_controller u_ctrl (
    .clock, .reset, .run, .fetch_word, .im_address, .im_read,
    .insn, .ctrl, .halted, .ins_cnt
  );

  instr_mem u_imem (
    .clock, .load(im_load), .load_addr(im_load_addr), .load_data(im_load_data),
    .read(im_read), .read_addr(im_address), .read_data(fetch_word)
  );

  // rb and imm5 share bits 14:10
  reg_file u_regs (
    .clock, .reset,
    .ra_addr(insn.alu_f.ra), .rb_addr(insn.alu_f.rb_imm5), .rt_addr(insn.alu_f.rt),
    .dbg_addr(dbg_reg_addr), .write(ctrl.reg_write), .write_data(writeback_data),
    .ra_data, .rb_data, .rt_data, .dbg_data(dbg_reg_data)
  );

  exec_unit u_exec (
    .clock, .reset, .insn, .ctrl, .ra_data, .rb_data, .dm_data,
    .alu_result, .writeback_data
  );

  data_mem u_dmem (
    .clock, .addr(alu_result[`CPU_DM_AW-1:0]), .dbg_addr(dbg_dm_addr),
    .read(ctrl.dm_read), .write(ctrl.dm_write), .write_data(rt_data),
    .read_data(dm_data), .dbg_data(dbg_dm_data)
  );

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module data_mem (
  input  wire logic                   clock,
  input  wire logic [`CPU_DM_AW-1:0]  addr,
  input  wire logic [`CPU_DM_AW-1:0]  dbg_addr,
  input  wire logic                   read,
  input  wire logic                   write,
  input  wire logic [`CPU_DATA_W-1:0] write_data,
  output logic [`CPU_DATA_W-1:0]      read_data,
  output logic [`CPU_DATA_W-1:0]      dbg_data
);

  logic [`CPU_DATA_W-1:0] mem [2**`CPU_DM_AW];

  always_ff @(posedge clock) begin
    if (write) begin
      mem[addr] <= write_data;
    end
    if (read) begin
      read_data <= mem[addr];
    end
  end

  assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module exec_unit (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire cpu_pkg::insn_u         insn,
  input  wire cpu_pkg::ctrl_s         ctrl,
  input  wire logic [`CPU_DATA_W-1:0] ra_data,
  input  wire logic [`CPU_DATA_W-1:0] rb_data,
  input  wire logic [`CPU_DATA_W-1:0] dm_data,
  output logic [`CPU_DATA_W-1:0]      alu_result,
  output logic [`CPU_DATA_W-1:0]      writeback_data
);

  logic [`CPU_DATA_W-1:0]         imm_ext;
  logic [`CPU_DATA_W-1:0]         op1;
  logic [`CPU_DATA_W-1:0]         op2;
  logic [`CPU_DATA_W-1:0]         alu_out;
  logic [2*`CPU_DATA_W-1:0]       rot_pair;
  logic [$clog2(`CPU_DATA_W)-1:0] shamt;

  always_comb begin
    case (ctrl.imm_sel)
      cpu_pkg::imm15_se:
        imm_ext = {{(`CPU_DATA_W-15){insn.imm15_f.imm15[14]}}, insn.imm15_f.imm15};
      cpu_pkg::imm15_ze:
        imm_ext = {{(`CPU_DATA_W-15){1'b0}}, insn.imm15_f.imm15};
      cpu_pkg::imm20_se:
        imm_ext = {{(`CPU_DATA_W-20){insn.imm20_f.imm20[19]}}, insn.imm20_f.imm20};
      default:
        imm_ext = {{(`CPU_DATA_W-5){1'b0}}, insn.alu_f.rb_imm5};
    endcase
  end

  // movi has no base register since its ra bits belong to imm20
  assign op1 = (ctrl.src1_sel == cpu_pkg::src_imm) ? '0 : ra_data;

  always_comb begin
    case (ctrl.src2_sel)
      cpu_pkg::src_imm: op2 = imm_ext;
      cpu_pkg::src_addr: begin
        // indexed form scales rb and offset form uses imm15
        if (insn.ls_f.opcode == cpu_pkg::op_type_ls) begin
          op2 = rb_data << insn.ls_f.sv;
        end else begin
          op2 = imm_ext;
        end
      end
      default: op2 = rb_data;
    endcase
  end

  assign shamt    = op2[$clog2(`CPU_DATA_W)-1:0];
  assign rot_pair = {op1, op1} >> shamt;

  always_comb begin
    case (ctrl.alu_op)
      cpu_pkg::alu_sub:  alu_out = op1 - op2;
      cpu_pkg::alu_and:  alu_out = op1 & op2;
      cpu_pkg::alu_or:   alu_out = op1 | op2;
      cpu_pkg::alu_xor:  alu_out = op1 ^ op2;
      cpu_pkg::alu_sll:  alu_out = op1 << shamt;
      cpu_pkg::alu_srl:  alu_out = op1 >> shamt;
      cpu_pkg::alu_rotr: alu_out = rot_pair[`CPU_DATA_W-1:0];
      default:           alu_out = op1 + op2;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result <= '0;
    end else if (ctrl.alu_execute) begin
      alu_result <= alu_out;
    end
  end

  assign writeback_data = ctrl.writeback_from_dm ? dm_data : alu_result;

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module reg_file (
  input  wire logic                   clock,
  input  wire logic                   reset,
  input  wire logic [`CPU_REG_AW-1:0] ra_addr,
  input  wire logic [`CPU_REG_AW-1:0] rb_addr,
  input  wire logic [`CPU_REG_AW-1:0] rt_addr,
  input  wire logic [`CPU_REG_AW-1:0] dbg_addr,
  input  wire logic                   write,
  input  wire logic [`CPU_DATA_W-1:0] write_data,
  output logic [`CPU_DATA_W-1:0]      ra_data,
  output logic [`CPU_DATA_W-1:0]      rb_data,
  output logic [`CPU_DATA_W-1:0]      rt_data,
  output logic [`CPU_DATA_W-1:0]      dbg_data
);

  logic [`CPU_DATA_W-1:0] regs [2**`CPU_REG_AW];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (write) begin
      regs[rt_addr] <= write_data;
    end
  end

  // rt port feeds store data
  assign ra_data  = regs[ra_addr];
  assign rb_data  = regs[rb_addr];
  assign rt_data  = regs[rt_addr];
  assign dbg_data = regs[dbg_addr];

endmodule

`default_nettype wire

//--- design/instr_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module instr_mem (
  input  wire logic                   clock,
  input  wire logic                   load,
  input  wire logic [`CPU_IM_AW-1:0]  load_addr,
  input  wire logic [`CPU_DATA_W-1:0] load_data,
  input  wire logic                   read,
  input  wire logic [`CPU_IM_AW-1:0]  read_addr,
  output cpu_pkg::insn_u              read_data
);

  logic [`CPU_DATA_W-1:0] mem [2**`CPU_IM_AW];

  always_ff @(posedge clock) begin
    if (load) begin
      mem[load_addr] <= load_data;
    end
  end

  // fetch word holds until the next read strobe
  always_ff @(posedge clock) begin
    if (read) begin
      read_data <= mem[read_addr];
    end
  end

endmodule

`default_nettype wire

//--- design/ir_controller.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_cfg.svh"

module ir_controller (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  run,
  input  wire cpu_pkg::insn_u        fetch_word,
  output logic [`CPU_IM_AW-1:0]      im_address,
  output logic                       im_read,
  output cpu_pkg::insn_u             insn,
  output cpu_pkg::ctrl_s             ctrl,
  output logic                       halted,
  output logic [`CPU_CNT_W-1:0]      ins_cnt
);

  localparam logic [`CPU_IM_AW-1:0] im_start = `CPU_IM_AW'(`CPU_IM_START);

  typedef enum logic [2:0] {
    stop_st     = 3'b000,
    fetch_st    = 3'b001,
    exe_st      = 3'b010,
    write_st    = 3'b011,
    lw_fetch_st = 3'b100,
    lw_write_st = 3'b101,
    sw_fetch_st = 3'b110,
    sw_write_st = 3'b111
  } state_e;

  state_e                state;
  state_e                state_nxt;
  logic [`CPU_IM_AW-1:0] pc;
  logic                  zero_word;
  logic                  is_nop;
  logic                  is_load;
  logic                  is_store;

  assign im_address = pc + im_start;
  assign im_read    = (state == stop_st) && run && !halted;
  assign zero_word  = (fetch_word == '0);

  assign is_nop = (insn.alu_f.opcode == cpu_pkg::op_type_basic) &&
                  (insn.alu_f.sub == cpu_pkg::sub_srli) && (insn.alu_f.rb_imm5 == '0);
  assign is_load = (insn.imm15_f.opcode == cpu_pkg::op_lwi) ||
                   ((insn.ls_f.opcode == cpu_pkg::op_type_ls) && (insn.ls_f.sub == cpu_pkg::ls_lw));
  assign is_store = (insn.imm15_f.opcode == cpu_pkg::op_swi) ||
                    ((insn.ls_f.opcode == cpu_pkg::op_type_ls) && (insn.ls_f.sub == cpu_pkg::ls_sw));

  // every instruction takes the whole eight-state walk
  always_comb begin
    state_nxt = state;
    case (state)
      stop_st:     if (im_read) state_nxt = fetch_st;
      fetch_st:    state_nxt = zero_word ? stop_st : exe_st;
      exe_st:      state_nxt = lw_fetch_st;
      lw_fetch_st: state_nxt = lw_write_st;
      lw_write_st: state_nxt = write_st;
      write_st:    state_nxt = sw_fetch_st;
      sw_fetch_st: state_nxt = sw_write_st;
      sw_write_st: state_nxt = stop_st;
      default:     state_nxt = stop_st;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= stop_st;
      pc      <= '0;
      ins_cnt <= '0;
      halted  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == fetch_st) begin
        if (zero_word) begin
          halted <= 1'b1;
        end else begin
          ins_cnt <= ins_cnt + `CPU_CNT_W'd1;
        end
      end
      if (state == sw_write_st) begin
        pc <= pc + `CPU_IM_AW'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (state == fetch_st) begin
      insn <= fetch_word;
    end
  end

  always_comb begin
    ctrl          = '0;
    ctrl.imm_sel  = cpu_pkg::imm5_ze;
    ctrl.src1_sel = cpu_pkg::src_reg;
    ctrl.src2_sel = cpu_pkg::src_reg;
    ctrl.alu_op   = cpu_pkg::alu_add;
    case (insn.alu_f.opcode)
      cpu_pkg::op_type_basic: begin
        case (insn.alu_f.sub)
          cpu_pkg::sub_sub:   ctrl.alu_op = cpu_pkg::alu_sub;
          cpu_pkg::sub_and:   ctrl.alu_op = cpu_pkg::alu_and;
          cpu_pkg::sub_or:    ctrl.alu_op = cpu_pkg::alu_or;
          cpu_pkg::sub_xor:   ctrl.alu_op = cpu_pkg::alu_xor;
          cpu_pkg::sub_slli:  ctrl.alu_op = cpu_pkg::alu_sll;
          cpu_pkg::sub_srli:  ctrl.alu_op = cpu_pkg::alu_srl;
          cpu_pkg::sub_rotri: ctrl.alu_op = cpu_pkg::alu_rotr;
          default:            ctrl.alu_op = cpu_pkg::alu_add;
        endcase
        // shifts take imm5 in place of rb
        if (insn.alu_f.sub inside {cpu_pkg::sub_slli, cpu_pkg::sub_srli,
                                   cpu_pkg::sub_rotri}) begin
          ctrl.src2_sel = cpu_pkg::src_imm;
        end
      end
      cpu_pkg::op_addi: begin
        ctrl.imm_sel  = cpu_pkg::imm15_se;
        ctrl.src2_sel = cpu_pkg::src_imm;
      end
      cpu_pkg::op_ori: begin
        ctrl.imm_sel  = cpu_pkg::imm15_ze;
        ctrl.src2_sel = cpu_pkg::src_imm;
        ctrl.alu_op   = cpu_pkg::alu_or;
      end
      cpu_pkg::op_xori: begin
        ctrl.imm_sel  = cpu_pkg::imm15_ze;
        ctrl.src2_sel = cpu_pkg::src_imm;
        ctrl.alu_op   = cpu_pkg::alu_xor;
      end
      cpu_pkg::op_lwi, cpu_pkg::op_swi: begin
        ctrl.imm_sel  = cpu_pkg::imm15_ze;
        ctrl.src1_sel = cpu_pkg::src_addr;
        ctrl.src2_sel = cpu_pkg::src_addr;
      end
      cpu_pkg::op_movi: begin
        ctrl.imm_sel  = cpu_pkg::imm20_se;
        ctrl.src1_sel = cpu_pkg::src_imm;
        ctrl.src2_sel = cpu_pkg::src_imm;
      end
      cpu_pkg::op_type_ls: begin
        ctrl.src1_sel = cpu_pkg::src_addr;
        ctrl.src2_sel = cpu_pkg::src_addr;
      end
      default: ;
    endcase

    ctrl.writeback_from_dm = is_load;
    ctrl.reg_read    = (state == exe_st) || ((state == sw_fetch_st) && is_store);
    ctrl.alu_execute = (state == exe_st);
    ctrl.dm_read     = (state == lw_fetch_st) && is_load;
    ctrl.reg_write   = (state == write_st) && !is_nop && !is_store;
    ctrl.dm_write    = (state == sw_write_st) && is_store;
  end

endmodule

`default_nettype wire

//--- design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef enum logic [5:0] {
    op_lwi        = 6'b000010,
    op_swi        = 6'b001010,
    op_type_ls    = 6'b011100,
    op_type_basic = 6'b100000,
    op_movi       = 6'b100010,
    op_addi       = 6'b101000,
    op_xori       = 6'b101011,
    op_ori        = 6'b101100
  } opcode_e;

  // srli with zero shift doubles as nop
  typedef enum logic [4:0] {
    sub_add   = 5'b00000,
    sub_sub   = 5'b00001,
    sub_and   = 5'b00010,
    sub_xor   = 5'b00011,
    sub_or    = 5'b00100,
    sub_slli  = 5'b01000,
    sub_srli  = 5'b01001,
    sub_rotri = 5'b01011
  } basic_sub_e;

  typedef enum logic [7:0] {
    ls_lw = 8'b00000010,
    ls_sw = 8'b00001010
  } ls_sub_e;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_rotr
  } alu_op_e;

  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_e;

  typedef enum logic [1:0] {
    src_reg  = 2'b00,
    src_imm  = 2'b01,
    src_addr = 2'b10
  } src_sel_e;

  typedef struct packed {
    logic       spare;
    opcode_e    opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb_imm5;
    logic [1:0] sv;
    logic [2:0] pad;
    basic_sub_e sub;
  } alu_fmt_s;

  typedef struct packed {
    logic        spare;
    opcode_e     opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm15;
  } imm15_fmt_s;

  typedef struct packed {
    logic        spare;
    opcode_e     opcode;
    logic [4:0]  rt;
    logic [19:0] imm20;
  } imm20_fmt_s;

  typedef struct packed {
    logic       spare;
    opcode_e    opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [1:0] sv;
    ls_sub_e    sub;
  } ls_fmt_s;

  // one instruction word, four decodings
  typedef union packed {
    alu_fmt_s   alu_f;
    imm15_fmt_s imm15_f;
    imm20_fmt_s imm20_f;
    ls_fmt_s    ls_f;
  } insn_u;

  typedef struct packed {
    logic     reg_read;
    logic     alu_execute;
    logic     reg_write;
    logic     dm_read;
    logic     dm_write;
    imm_sel_e imm_sel;
    src_sel_e src1_sel;
    src_sel_e src2_sel;
    alu_op_e  alu_op;
    logic     writeback_from_dm;
  } ctrl_s;

endpackage

`default_nettype wire

//--- include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data and instruction word
`define CPU_DATA_W 32
`define CPU_REG_AW 5

// 1024-word instruction memory, 256-word data memory
`define CPU_IM_AW 10
`define CPU_DM_AW 8

// program starts at this word in instruction memory
`define CPU_IM_START 'h7F

`define CPU_CNT_W 32

`endif
